//--- filelist.f
tempmon_pkg.sv
apb_pkg.sv
drp_poller.sv
alarm_monitor.sv
apb_regs.sv
tempmon_top.sv
drp_sensor_model.sv
tb_tempmon.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench, pass only if the pass message shows up
cd "$(dirname "$0")" \
  && verilator --binary --assert --timing -f filelist.f --top-module tb_tempmon -o tb_tempmon \
  && out=$(./obj_dir/tb_tempmon) \
  && printf '%s\n' "$out" \
  && printf '%s\n' "$out" | grep -qx "All checks passed" \
  || exit 1

//--- tb_tempmon.sv
`timescale 1ns/1ps

module tb_tempmon import tempmon_pkg::*, apb_pkg::*; ();

  localparam int POLL_PERIOD  = 50;           // Update period under test in cycles
  localparam int TEST_PERIODS = 2 + 3 + 1 + 6; // Polling, hysteresis, event, timeout
  localparam int MARGIN       = 10;
  localparam int WATCHDOG_NS  = TEST_PERIODS * POLL_PERIOD * MARGIN * 20;
  localparam int POLL_LIMIT   = 100;          // APB reads before a wait gives up

  logic             clk;
  logic             rst;
  apb_req_t         apb_req;
  apb_rsp_t         apb_rsp;
  drp_req_t         drp_req;
  drp_rsp_t         drp_rsp;
  logic             read;
  logic             ot;
  logic             irq;
  logic [2:0][15:0] ch_value;  // Sensor contents
  logic             mute;
  logic [15:0]      exp_val [3] = '{default: 16'h0000}; // Expected channel values
  int               errors = 0;
  int               checks = 0;
  int               read_cnt = 0; // den pulses seen
  int               seed;

  tempmon_top dut (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .drp_req (drp_req),
    .drp_rsp (drp_rsp),
    .read    (read),
    .ot      (ot),
    .irq     (irq)
  );

  drp_sensor_model sensor (
    .clk      (clk),
    .rst      (rst),
    .drp_req  (drp_req),
    .drp_rsp  (drp_rsp),
    .ch_value (ch_value),
    .mute     (mute)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    if (read) begin
      read_cnt++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, test did not finish", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Write lands on the access-phase edge
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1 apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    #1 apb_req.penable = 1'b1;
    @(posedge clk);
    #1 apb_req = '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    #1 apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
    @(posedge clk);
    #1 apb_req.penable = 1'b1;
    #1;
    data = apb_rsp.prdata; // Mid access phase
    err  = apb_rsp.pslverr;
    check("pready", 32'(apb_rsp.pready), 32'd1);
    @(posedge clk);
    #1 apb_req = '0;
  endtask

  task automatic load_channel(input sensor_ch_e ch, input logic [15:0] value);
    ch_value[ch] = value;
    exp_val[ch]  = value;
  endtask

  task automatic mute_sensor(input logic on);
    mute = on;
  endtask

  // Enable, wait for n more sweeps, disable and let the poller drain
  task automatic run_sweeps(input int n, input logic irq_on);
    logic [31:0] start;
    logic [31:0] cnt;
    logic        err;
    int          polls;
    apb_read(SAMPLE_COUNT, start, err);
    apb_write(CTRL, {30'd0, irq_on, 1'b1});
    cnt   = start;
    polls = 0;
    while (cnt < start + 32'(n) && polls < POLL_LIMIT) begin
      apb_read(SAMPLE_COUNT, cnt, err);
      polls++;
    end
    if (cnt < start + 32'(n)) begin
      errors++;
      $display("Sweep count stuck at %0d while waiting for %0d", cnt, start + 32'(n));
    end
    apb_write(CTRL, {30'd0, irq_on, 1'b0});
    idle(40);
  endtask

  task automatic reset_defaults;
    logic [31:0] d;
    logic        err;
    apb_read(CTRL, d, err);
    check("CTRL", d, 32'd0);
    apb_read(STATUS, d, err);
    check("STATUS", d, 32'd0);
    apb_read(SAMPLE_COUNT, d, err);
    check("SAMPLE_COUNT", d, 32'd0);
    apb_read(PERIOD, d, err);
    check("PERIOD", d, PERIOD_RESET);
    apb_read(OT_HI, d, err);
    check("OT_HI", d, {16'd0, OT_HI_RESET});
    apb_read(OT_LO, d, err);
    check("OT_LO", d, {16'd0, OT_LO_RESET});
    check("irq", 32'(irq), 32'd0);
    check("ot", 32'(ot), 32'd0);
    idle(50);
    check("read pulses while disabled", 32'(read_cnt), 32'd0);
  endtask

  task automatic poll_channels;
    logic [31:0] c0;
    logic [31:0] c1;
    logic [31:0] d;
    logic        err;
    int          r0;
    load_channel(CH_TEMP, 16'($random(seed)) & 16'h7FFF); // Below OT_LO so the alarm starts clear
    load_channel(CH_VCCINT, 16'($random(seed)));
    load_channel(CH_VCCAUX, 16'($random(seed)));
    apb_write(PERIOD, 32'(POLL_PERIOD));
    apb_read(SAMPLE_COUNT, c0, err);
    r0 = read_cnt;
    run_sweeps(2, 1'b0);
    apb_read(SAMPLE_COUNT, c1, err);
    check("SAMPLE_COUNT advanced by 2", 32'(c1 >= c0 + 32'd2), 32'd1);
    check("read pulses per sweep", 32'(read_cnt - r0), 3 * (c1 - c0)); // Whole groups of three
    apb_read(TEMP, d, err);
    check("TEMP", d, {16'd0, exp_val[CH_TEMP]});
    apb_read(VCCINT, d, err);
    check("VCCINT", d, {16'd0, exp_val[CH_VCCINT]});
    apb_read(VCCAUX, d, err);
    check("VCCAUX", d, {16'd0, exp_val[CH_VCCAUX]});
  endtask

  task automatic hysteresis_band;
    logic [31:0] d;
    logic        err;
    load_channel(CH_TEMP, OT_HI_RESET); // Exactly at the set threshold
    run_sweeps(1, 1'b0);
    check("ot at OT_HI", 32'(ot), 32'd1);
    apb_read(STATUS, d, err);
    check("STATUS.ot at OT_HI", 32'(d[0]), 32'd1);
    load_channel(CH_TEMP, OT_HI_RESET - 16'h0400); // Inside the band
    run_sweeps(1, 1'b0);
    check("ot inside band", 32'(ot), 32'd1);
    load_channel(CH_TEMP, OT_LO_RESET - 16'd1);
    run_sweeps(1, 1'b0);
    check("ot below OT_LO", 32'(ot), 32'd0);
  endtask

  task automatic event_and_irq;
    logic [31:0] d;
    logic        err;
    apb_write(STATUS, 32'h2); // Drop any event left from earlier tests
    apb_read(STATUS, d, err);
    check("STATUS.event before", 32'(d[1]), 32'd0);
    load_channel(CH_TEMP, 16'hC000);
    run_sweeps(1, 1'b1);
    apb_read(STATUS, d, err);
    check("STATUS.event on rise", 32'(d[1]), 32'd1);
    check("irq on rise", 32'(irq), 32'd1);
    apb_write(STATUS, 32'h0); // Writing 0 does nothing
    apb_read(STATUS, d, err);
    check("STATUS.event after write 0", 32'(d[1]), 32'd1);
    check("irq after write 0", 32'(irq), 32'd1);
    apb_write(STATUS, 32'h2);
    apb_read(STATUS, d, err);
    check("STATUS.event after clear", 32'(d[1]), 32'd0);
    check("irq after clear", 32'(irq), 32'd0);
  endtask

  task automatic apb_error_response;
    logic [31:0] d;
    logic        err;
    apb_read(8'h24, d, err);
    check("pslverr at 0x24", 32'(err), 32'd1);
    apb_read(8'h06, d, err);
    check("pslverr at 0x06", 32'(err), 32'd1);
    apb_read(OT_HI, d, err);
    check("pslverr at OT_HI", 32'(err), 32'd0);
    apb_write(TEMP, 32'h0000_1234);
    apb_read(TEMP, d, err);
    check("TEMP after write", d, {16'd0, exp_val[CH_TEMP]});
  endtask

  task automatic timeout_recovery;
    logic [31:0] c0;
    logic [31:0] c1;
    logic [31:0] d;
    logic        err;
    int          polls;
    mute_sensor(1'b1);
    apb_read(SAMPLE_COUNT, c0, err);
    apb_write(CTRL, 32'h1);
    d     = '0;
    polls = 0;
    while (!d[2] && polls < POLL_LIMIT) begin
      apb_read(STATUS, d, err);
      polls++;
    end
    if (!d[2]) begin
      errors++;
      $display("DRP timeout flag never set while the sensor was muted");
    end
    idle(3 * POLL_PERIOD);
    apb_read(SAMPLE_COUNT, c1, err);
    check("SAMPLE_COUNT while muted", c1, c0);
    apb_write(CTRL, 32'h0);
    idle(80); // Outlasts a pending DRP timeout
    mute_sensor(1'b0);
    apb_write(STATUS, 32'h4);
    apb_read(STATUS, d, err);
    check("STATUS.timeout after clear", 32'(d[2]), 32'd0);
    load_channel(CH_VCCAUX, 16'($random(seed)));
    run_sweeps(1, 1'b0);
    apb_read(SAMPLE_COUNT, c1, err);
    check("SAMPLE_COUNT resumed", 32'(c1 > c0), 32'd1);
    apb_read(VCCAUX, d, err);
    check("VCCAUX after resume", d, {16'd0, exp_val[CH_VCCAUX]});
    apb_read(STATUS, d, err);
    check("STATUS.timeout after resume", 32'(d[2]), 32'd0);
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    apb_req  = '0;
    ch_value = '0;
    mute     = 1'b0;
    seed     = 32'hbda5;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    reset_defaults();
    poll_channels();
    hysteresis_band();
    event_and_irq();
    apb_error_response();
    timeout_recovery();
    $display("Errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- drp_sensor_model.sv
`timescale 1ns/1ps

module drp_sensor_model import tempmon_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  drp_req_t         drp_req,
  output drp_rsp_t         drp_rsp,
  input  logic [2:0][15:0] ch_value, // Register contents, indexed by sensor_ch_e
  input  logic             mute      // Swallow requests, never answer
);

  localparam int LATENCY = 3; // Cycles from den to drdy

  logic [LATENCY-1:0] busy;   // One bit per pipeline stage
  logic [6:0]         addr_q [LATENCY];
  logic [15:0]        dout;

  // Request pipeline, reads only
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      busy <= {busy[LATENCY-2:0], drp_req.den && !drp_req.dwe && !mute};
    end
  end

  always_ff @(posedge clk) begin
    addr_q[0] <= drp_req.daddr;
    for (int i = 1; i < LATENCY; i++) begin
      addr_q[i] <= addr_q[i-1];
    end
  end

  // Addressed status register
  always_comb begin
    case (addr_q[LATENCY-1])
      ADDR_TEMP:   dout = ch_value[CH_TEMP];
      ADDR_VCCINT: dout = ch_value[CH_VCCINT];
      ADDR_VCCAUX: dout = ch_value[CH_VCCAUX];
      default:     dout = 16'h0000; // Unmapped reads as zero
    endcase
  end

  assign drp_rsp = '{
    drdy: busy[LATENCY-1],
    dout: busy[LATENCY-1] ? dout : 16'h0000 // Bus idles at zero
  };

endmodule

//--- tempmon_top.sv
`timescale 1ns/1ps

module tempmon_top import tempmon_pkg::*, apb_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  output drp_req_t drp_req,
  input  drp_rsp_t drp_rsp,
  output logic     read,
  output logic     ot,
  output logic     irq
);

  logic        enable;
  logic        irq_en;
  logic        event_clear;
  logic [31:0] period;
  logic [15:0] ot_hi;
  logic [15:0] ot_lo;
  sample_t     sample;      // Poller result to monitor and registers
  logic        sweep_done;
  logic        drp_timeout;
  logic        ot_event;

  drp_poller u_poller (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .period      (period),
    .drp_req     (drp_req),
    .drp_rsp     (drp_rsp),
    .sample      (sample),
    .sweep_done  (sweep_done),
    .read        (read),
    .drp_timeout (drp_timeout)
  );

  alarm_monitor u_alarm (
    .clk         (clk),
    .rst         (rst),
    .sample      (sample),
    .ot_hi       (ot_hi),
    .ot_lo       (ot_lo),
    .irq_en      (irq_en),
    .event_clear (event_clear),
    .ot_active   (ot),          // Over-temp level goes straight out
    .ot_event    (ot_event),
    .irq         (irq)
  );

  apb_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .sample      (sample),
    .sweep_done  (sweep_done),
    .drp_timeout (drp_timeout),
    .ot_active   (ot),
    .ot_event    (ot_event),
    .enable      (enable),
    .irq_en      (irq_en),
    .event_clear (event_clear),
    .period      (period),
    .ot_hi       (ot_hi),
    .ot_lo       (ot_lo)
  );

endmodule

//--- apb_regs.sv
`timescale 1ns/1ps

module apb_regs import tempmon_pkg::*, apb_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,
  input  sample_t     sample,
  input  logic        sweep_done,
  input  logic        drp_timeout,
  input  logic        ot_active,
  input  logic        ot_event,
  output logic        enable,
  output logic        irq_en,
  output logic        event_clear,
  output logic [31:0] period,
  output logic [15:0] ot_hi,
  output logic [15:0] ot_lo
);

  reg_addr_e   addr;
  logic        access;        // APB access phase
  logic        wr_en;
  logic        rd_en;
  logic        addr_ok;       // Offset is in the register map
  logic        status_wr;
  logic        timeout_clear;
  logic [31:0] rd_data;
  logic [15:0] samples [3];   // Latest result per channel
  logic [31:0] sweep_cnt;
  logic        timeout_flag;  // Sticky DRP timeout

  assign addr   = reg_addr_e'(apb_req.paddr);
  assign access = apb_req.psel && apb_req.penable;
  assign wr_en  = access && apb_req.pwrite;
  assign rd_en  = access && !apb_req.pwrite;

  // W1C strobes out of a STATUS write
  assign status_wr     = wr_en && (addr == STATUS);
  assign event_clear   = status_wr && apb_req.pwdata[1];
  assign timeout_clear = status_wr && apb_req.pwdata[2];

  // Read mux and address check
  always_comb begin
    addr_ok = 1'b1;
    rd_data = '0;
    case (addr)
      CTRL:         rd_data = {30'd0, irq_en, enable};
      PERIOD:       rd_data = period;
      OT_HI:        rd_data = {16'd0, ot_hi};
      OT_LO:        rd_data = {16'd0, ot_lo};
      TEMP:         rd_data = {16'd0, samples[CH_TEMP]};
      VCCINT:       rd_data = {16'd0, samples[CH_VCCINT]};
      VCCAUX:       rd_data = {16'd0, samples[CH_VCCAUX]};
      STATUS:       rd_data = {29'd0, timeout_flag, ot_event, ot_active};
      SAMPLE_COUNT: rd_data = sweep_cnt;
      default:      addr_ok = 1'b0;
    endcase
  end

  // Control and thresholds, written at the access-phase edge
  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
      irq_en <= 1'b0;
      period <= PERIOD_RESET;
      ot_hi  <= OT_HI_RESET;
      ot_lo  <= OT_LO_RESET;
    end else if (wr_en) begin
      case (addr)
        CTRL: begin
          enable <= apb_req.pwdata[0];
          irq_en <= apb_req.pwdata[1];
        end
        PERIOD:  period <= (apb_req.pwdata == 32'd0) ? 32'd1 : apb_req.pwdata; // Floor of 1
        OT_HI:   ot_hi  <= apb_req.pwdata[15:0];
        OT_LO:   ot_lo  <= apb_req.pwdata[15:0];
        default: ; // Read-only and unmapped offsets drop the write
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample.valid && (sample.ch <= CH_VCCAUX)) begin
      samples[sample.ch] <= sample.value;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_cnt    <= '0;
      timeout_flag <= 1'b0;
    end else begin
      if (sweep_done) begin
        sweep_cnt <= sweep_cnt + 32'd1; // Full three-channel sweeps only
      end
      if (drp_timeout) begin
        timeout_flag <= 1'b1;
      end else if (timeout_clear) begin
        timeout_flag <= 1'b0;
      end
    end
  end

  assign apb_rsp = '{
    prdata:  rd_en ? rd_data : 32'd0,
    pready:  1'b1,
    pslverr: access && !addr_ok
  };

  a_penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
    apb_req.penable |-> apb_req.psel);

  // With pready tied high every setup phase is followed by its access phase
  a_setup_then_access: assert property (@(posedge clk) disable iff (rst)
    (apb_req.psel && !apb_req.penable) |=> (apb_req.psel && apb_req.penable));

endmodule

//--- alarm_monitor.sv
`timescale 1ns/1ps

module alarm_monitor import tempmon_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  sample_t     sample,
  input  logic [15:0] ot_hi,
  input  logic [15:0] ot_lo,
  input  logic        irq_en,
  input  logic        event_clear,
  output logic        ot_active,
  output logic        ot_event,
  output logic        irq
);

  logic temp_valid; // Temperature result this cycle
  logic ot_next;
  logic ot_rise;

  assign temp_valid = sample.valid && (sample.ch == CH_TEMP); // Supply channels ignored

  // Hysteresis band between ot_lo and ot_hi
  always_comb begin
    ot_next = ot_active; // Hold inside the band
    if (temp_valid) begin
      if (sample.value >= ot_hi) begin
        ot_next = 1'b1;
      end else if (sample.value < ot_lo) begin
        ot_next = 1'b0;
      end
    end
  end

  assign ot_rise = ot_next && !ot_active;

  always_ff @(posedge clk) begin
    if (rst) begin
      ot_active <= 1'b0;
      ot_event  <= 1'b0;
      irq       <= 1'b0;
    end else begin
      ot_active <= ot_next;
      if (ot_rise) begin
        ot_event <= 1'b1; // New alarm wins over a clear in the same cycle
      end else if (event_clear) begin
        ot_event <= 1'b0;
      end
      irq <= ot_event && irq_en; // Level interrupt one cycle behind the flag
    end
  end

  a_event_on_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(ot_event) |-> $rose(ot_active));

endmodule

//--- drp_poller.sv
`timescale 1ns/1ps

module drp_poller import tempmon_pkg::*; #(
  parameter int unsigned DRP_TIMEOUT = 64 // Cycles allowed from den to drdy
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        enable,
  input  logic [31:0] period,
  output drp_req_t    drp_req,
  input  drp_rsp_t    drp_rsp,
  output sample_t     sample,
  output logic        sweep_done,
  output logic        read,
  output logic        drp_timeout
);

  poll_state_e state;
  sensor_ch_e  ch;          // Channel being read
  logic [31:0] tick_cnt;    // Update period counter
  logic        tick;
  logic [31:0] wait_cnt;    // Cycles spent in WAIT
  logic        wait_last;
  logic        smp_valid;
  sensor_ch_e  smp_ch;
  logic [15:0] smp_value;
  logic        pending;     // A read has been issued and not answered

  assign tick      = enable && (tick_cnt >= period - 32'd1); // >= copes with period shrinking
  assign wait_last = (wait_cnt == DRP_TIMEOUT - 32'd1);

  // Update tick, restarts from 0 whenever enable is low
  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt <= '0;
    end else if (!enable || tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      ch          <= CH_TEMP;
      wait_cnt    <= '0;
      smp_valid   <= 1'b0;
      sweep_done  <= 1'b0;
      drp_timeout <= 1'b0;
    end else begin
      smp_valid   <= 1'b0; // Strobes default low
      sweep_done  <= 1'b0;
      drp_timeout <= 1'b0;
      case (state)
        IDLE: begin
          if (tick) begin // Ticks while busy are simply not seen
            ch    <= CH_TEMP;
            state <= ISSUE;
          end
        end
        ISSUE: begin
          wait_cnt <= '0;
          state    <= WAIT;
        end
        WAIT: begin
          if (drp_rsp.drdy) begin
            smp_valid  <= 1'b1;
            sweep_done <= (ch == CH_VCCAUX); // Aligned with the last sample strobe
            state      <= NEXT;
          end else if (wait_last) begin
            drp_timeout <= 1'b1; // Abandon the rest of the sweep
            state       <= IDLE;
          end else begin
            wait_cnt <= wait_cnt + 32'd1;
          end
        end
        NEXT: begin
          case (ch)
            CH_TEMP:   ch <= CH_VCCINT;
            CH_VCCINT: ch <= CH_VCCAUX;
            default:   ch <= CH_TEMP;
          endcase
          state <= (ch == CH_VCCAUX) ? IDLE : ISSUE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Capture dout on drdy
  always_ff @(posedge clk) begin
    if (state == WAIT && drp_rsp.drdy) begin
      smp_ch    <= ch;
      smp_value <= drp_rsp.dout;
    end
  end

  // Tracks the bus from the outside, independent of the FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (drp_req.den) begin
      pending <= 1'b1;
    end else if (drp_rsp.drdy || drp_timeout) begin
      pending <= 1'b0;
    end
  end

  assign drp_req = '{den: (state == ISSUE), dwe: 1'b0, daddr: ch_addr(ch)}; // Reads only
  assign read    = drp_req.den;
  assign sample  = '{valid: smp_valid, ch: smp_ch, value: smp_value};

  a_den_one_cycle: assert property (@(posedge clk) disable iff (rst)
    drp_req.den |=> !drp_req.den);

  a_den_not_pending: assert property (@(posedge clk) disable iff (rst)
    $rose(drp_req.den) |-> !pending);

endmodule

//--- apb_pkg.sv
package apb_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable; // High in the access phase
    logic        pwrite;
    logic [7:0]  paddr;   // Byte offset
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;  // Tied high, no wait states
    logic        pslverr;
  } apb_rsp_t;

  // Register offsets
  typedef enum logic [7:0] {
    CTRL         = 8'h00, // [0] enable, [1] irq_en
    PERIOD       = 8'h04, // Update period in cycles
    OT_HI        = 8'h08, // Over-temp set threshold
    OT_LO        = 8'h0C, // Over-temp release threshold
    TEMP         = 8'h10, // Read only
    VCCINT       = 8'h14, // Read only
    VCCAUX       = 8'h18, // Read only
    STATUS       = 8'h1C, // [0] ot, [1] event W1C, [2] DRP timeout W1C
    SAMPLE_COUNT = 8'h20  // Completed sweeps, read only
  } reg_addr_e;

  localparam logic [15:0] OT_HI_RESET = 16'hB000;
  localparam logic [15:0] OT_LO_RESET = 16'hA800;

endpackage

//--- tempmon_pkg.sv
package tempmon_pkg;

  // DRP request toward the sensor port
  typedef struct packed {
    logic       den;   // One-cycle enable per access
    logic       dwe;   // Write enable, held low here
    logic [6:0] daddr; // Status register address
  } drp_req_t;

  // DRP response from the sensor port
  typedef struct packed {
    logic        drdy; // One-cycle strobe, dout valid with it
    logic [15:0] dout;
  } drp_rsp_t;

  typedef enum logic [1:0] {
    CH_TEMP   = 2'd0,
    CH_VCCINT = 2'd1,
    CH_VCCAUX = 2'd2
  } sensor_ch_e;

  // One captured conversion result
  typedef struct packed {
    logic        valid; // Single-cycle strobe
    sensor_ch_e  ch;
    logic [15:0] value;
  } sample_t;

  typedef enum logic [1:0] {
    IDLE,  // Waiting for an update tick
    ISSUE, // den driven this cycle
    WAIT,  // Read outstanding
    NEXT   // Sample strobe out, pick next channel
  } poll_state_e;

  // Sensor status register map
  localparam logic [6:0] ADDR_TEMP   = 7'h00;
  localparam logic [6:0] ADDR_VCCINT = 7'h01;
  localparam logic [6:0] ADDR_VCCAUX = 7'h02;

  localparam logic [31:0] PERIOD_RESET = 32'd1000; // Cycles between sweeps after reset

  // Status register address of a channel
  function automatic logic [6:0] ch_addr(sensor_ch_e ch);
    case (ch)
      CH_VCCINT: return ADDR_VCCINT;
      CH_VCCAUX: return ADDR_VCCAUX;
      default:   return ADDR_TEMP;
    endcase
  endfunction

endpackage
